// File: rtl/fds_bus_map.sv
// combinational PRG and CHR address mapping, mirroring and CPU read-data selection
`timescale 1ns/10ps

module fds_bus_map (
	input  fds_bus_pkg::cpu_bus_t      cpu,
	input  fds_bus_pkg::ppu_addr_t     chr_ain,
	input  fds_disk_pkg::disk_status_t status,
	input  logic                       vertical,
	input  logic                       irq,
	input  logic                       fds_swap,
	input  fds_bus_pkg::cpu_data_t     prg_rdata,
	output fds_bus_pkg::cpu_data_t     prg_dout,
	output fds_bus_pkg::prg_addr_t     prg_aout,
	output logic                       prg_allow,
	output fds_bus_pkg::chr_addr_t     chr_aout,
	output logic                       vram_a10,
	output logic                       vram_ce
);

	logic       xfer_any;
	logic       port_lo;
	logic       port_hi;
	logic [5:0] prg_bank;
	logic       chr_a10;

	assign xfer_any = status.rd_active | status.wr_active;

	// BIOS port reads show the offset only outside a transfer
	assign port_lo = (cpu.addr == fds_bus_pkg::READ_LO || cpu.addr == fds_bus_pkg::WRITE_LO) &&
		!xfer_any;
	assign port_hi = (cpu.addr == fds_bus_pkg::READ_HI || cpu.addr == fds_bus_pkg::WRITE_HI) &&
		!xfer_any;

	always_comb begin
		if (cpu.addr == fds_bus_pkg::IRQ_STATUS)
			prg_dout = {7'd0, irq};
		else if (cpu.addr == fds_bus_pkg::DRIVE_STATUS)
			prg_dout = {5'd0, fds_swap, status.disk_end, fds_swap};
		else if (cpu.addr == fds_bus_pkg::POWER_STATUS)
			prg_dout = 8'h80;
		else if (port_lo)
			prg_dout = status.offset[7:0];
		else if (port_hi)
			prg_dout = {3'b111, status.offset[12:8]};
		else if (cpu.addr == fds_bus_pkg::SAVE_FLAG)
			prg_dout = {7'd0, status.saved};
		else
			prg_dout = prg_rdata;
	end

	// E000-FFFF is BIOS (bank 0) or the disk image while a transfer runs
	always_comb begin
		if (cpu.addr[15:13] == 3'b111)
			prg_bank = {1'b1, status.offset[17:13]} & {6{xfer_any}};
		else
			prg_bank = {4'b0001, cpu.addr[14:13]};
	end

	assign prg_aout = {3'b000, prg_bank, cpu.addr[12:0]};

	// writes: 6000-DFFF or anything during a disk write
	// reads: 6000-FFFF minus the BIOS port outside a transfer
	assign prg_allow = cpu.write ?
		(status.wr_active | (cpu.addr[15] ^ (cpu.addr[14] & cpu.addr[13]))) :
		((cpu.addr[15] & !port_lo & !port_hi) | (cpu.addr[15:13] == 3'b011));

	// nametable mirroring
	always_comb begin
		if (!chr_ain[13])
			chr_a10 = chr_ain[10];
		else if (vertical)
			chr_a10 = chr_ain[10];
		else
			chr_a10 = chr_ain[11];
	end

	assign chr_aout = {3'b100, 6'd0, chr_ain[12:11], chr_a10, chr_ain[9:0]};
	assign vram_a10 = chr_a10;
	assign vram_ce  = chr_ain[13];

endmodule

// File: rtl/fds_bus_pkg.sv
// CPU and PPU bus types and mapper register addresses, referenced by scoped name from each unit
package fds_bus_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [13:0] ppu_addr_t;
	typedef logic [21:0] prg_addr_t;
	typedef logic [21:0] chr_addr_t;

	// one CPU bus cycle, held stable across the strobe
	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t wdata;
		logic      write;
	} cpu_bus_t;

	// timer and drive registers
	localparam cpu_addr_t TIMER_LO     = 16'h4020;
	localparam cpu_addr_t TIMER_HI     = 16'h4021;
	localparam cpu_addr_t TIMER_CTRL   = 16'h4022;
	localparam cpu_addr_t DISK_ENABLE  = 16'h4023;
	localparam cpu_addr_t DRIVE_CTRL   = 16'h4025;
	localparam cpu_addr_t SIDE_SEL     = 16'h4027;
	localparam cpu_addr_t IRQ_STATUS   = 16'h4030;
	localparam cpu_addr_t DRIVE_STATUS = 16'h4032;
	localparam cpu_addr_t POWER_STATUS = 16'h4033;
	localparam cpu_addr_t SAVE_FLAG    = 16'h4208;

	// BIOS byte port, read twice in a row to open a transfer
	localparam cpu_addr_t WRITE_LO     = 16'hF4CD;
	localparam cpu_addr_t WRITE_HI     = 16'hF4CE;
	localparam cpu_addr_t READ_LO      = 16'hF4D0;
	localparam cpu_addr_t READ_HI      = 16'hF4D1;

endpackage

// File: rtl/fds_disk_pkg.sv
// disk image layout types, transfer states and the drive status bundle shared by drive and bus map
package fds_disk_pkg;

	// byte position within one side
	typedef logic [15:0] disk_pos_t;
	typedef logic [1:0]  disk_side_t;

	// byte offset into the whole image, header included
	typedef logic [17:0] image_off_t;

	// two-read handshake at the BIOS port
	typedef enum logic [1:0] {
		xfer_idle   = 2'd0,
		xfer_armed  = 2'd1,
		xfer_active = 2'd2
	} xfer_state_t;

	typedef struct packed {
		logic       rd_active;
		logic       wr_active;
		logic       disk_end;
		logic       saved;
		image_off_t offset;
	} disk_status_t;

endpackage

// File: rtl/fds_drive.sv
// drive control, transfer handshakes, disk position pointer and save flag for the disk image
`timescale 1ns/10ps

module fds_drive #(
	parameter int DISK_SIDE_BYTES   = 65500,
	parameter int DISK_HEADER_BYTES = 16
) (
	input  logic                       clk20,
	input  logic                       reset,
	input  logic                       cpu_ce,
	input  fds_bus_pkg::cpu_bus_t      cpu,
	input  fds_disk_pkg::disk_side_t   side_manual,
	output fds_disk_pkg::disk_status_t status,
	output logic                       vertical
);

	localparam fds_disk_pkg::disk_pos_t  LAST_POS =
		fds_disk_pkg::disk_pos_t'(DISK_SIDE_BYTES - 1);
	localparam fds_disk_pkg::image_off_t SIDE_LEN =
		fds_disk_pkg::image_off_t'(DISK_SIDE_BYTES);
	localparam fds_disk_pkg::image_off_t HEADER_LEN =
		fds_disk_pkg::image_off_t'(DISK_HEADER_BYTES);

	fds_disk_pkg::xfer_state_t rd_state;
	fds_disk_pkg::xfer_state_t wr_state;
	fds_disk_pkg::disk_pos_t   disk_pos;
	fds_disk_pkg::disk_side_t  side_auto;
	fds_disk_pkg::disk_side_t  side;
	fds_disk_pkg::image_off_t  side_off;
	logic                      disk_reset;
	logic                      write_en;
	logic                      saved;
	logic                      disk_end;
	logic                      rd_access;

	assign rd_access = !cpu.write;

	// side number wraps modulo 4
	assign side     = side_auto + side_manual;
	assign side_off = HEADER_LEN + SIDE_LEN * fds_disk_pkg::image_off_t'(side);
	assign disk_end = (disk_pos == LAST_POS);

	always_ff @(posedge clk20) begin
		if (reset) begin
			disk_reset <= 1'b0;
			write_en   <= 1'b0;
			vertical   <= 1'b0;
			side_auto  <= '0;
		end else if (cpu_ce && cpu.write) begin
			if (cpu.addr == fds_bus_pkg::DRIVE_CTRL) begin
				disk_reset <= cpu.wdata[1];
				write_en   <= !cpu.wdata[2];
				vertical   <= !cpu.wdata[3];
			end
			if (cpu.addr == fds_bus_pkg::SIDE_SEL)
				side_auto <= cpu.wdata[1:0];
		end
	end

	// any access that does not continue the handshake drops it
	always_ff @(posedge clk20) begin
		if (reset) begin
			rd_state <= fds_disk_pkg::xfer_idle;
			wr_state <= fds_disk_pkg::xfer_idle;
			saved    <= 1'b0;
		end else if (cpu_ce) begin
			if (rd_access && cpu.addr == fds_bus_pkg::READ_LO)
				rd_state <= fds_disk_pkg::xfer_armed;
			else if (rd_access && cpu.addr == fds_bus_pkg::READ_HI &&
				rd_state == fds_disk_pkg::xfer_armed)
				rd_state <= fds_disk_pkg::xfer_active;
			else
				rd_state <= fds_disk_pkg::xfer_idle;

			if (write_en && rd_access && cpu.addr == fds_bus_pkg::WRITE_LO)
				wr_state <= fds_disk_pkg::xfer_armed;
			else if (rd_access && cpu.addr == fds_bus_pkg::WRITE_HI &&
				wr_state == fds_disk_pkg::xfer_armed)
				wr_state <= fds_disk_pkg::xfer_active;
			else
				wr_state <= fds_disk_pkg::xfer_idle;

			if (wr_state == fds_disk_pkg::xfer_active)
				saved <= 1'b1;
		end
	end

	// position pointer, held at the last byte of the side
	always_ff @(posedge clk20) begin
		if (reset) begin
			disk_pos <= '0;
		end else if (cpu_ce) begin
			if (disk_reset)
				disk_pos <= '0;
			else if (rd_state == fds_disk_pkg::xfer_active && !disk_end)
				disk_pos <= disk_pos + 16'd1;
		end
	end

	assign status.rd_active = (rd_state == fds_disk_pkg::xfer_active);
	assign status.wr_active = (wr_state == fds_disk_pkg::xfer_active);
	assign status.disk_end  = disk_end;
	assign status.saved     = saved;
	assign status.offset    = side_off + fds_disk_pkg::image_off_t'(disk_pos);

	a_pos_in_side: assert property (
		@(posedge clk20) disable iff (reset)
		disk_pos <= LAST_POS
	);

	a_one_xfer: assert property (
		@(posedge clk20) disable iff (reset)
		!(status.rd_active && status.wr_active)
	);

endmodule

// File: rtl/fds_mapper.sv
// disk system mapper top level, joins the timer, drive and bus mapping units
`timescale 1ns/10ps

module fds_mapper #(
	parameter int DISK_SIDE_BYTES   = 65500,
	parameter int DISK_HEADER_BYTES = 16
) (
	input  logic                     clk20,
	input  logic                     reset,
	input  logic                     cpu_ce,
	input  fds_bus_pkg::cpu_bus_t    cpu,
	input  fds_bus_pkg::ppu_addr_t   chr_ain,
	input  fds_disk_pkg::disk_side_t side_manual,
	input  logic                     fds_swap,
	input  fds_bus_pkg::cpu_data_t   prg_rdata,
	output fds_bus_pkg::cpu_data_t   prg_dout,
	output fds_bus_pkg::prg_addr_t   prg_aout,
	output logic                     prg_allow,
	output fds_bus_pkg::chr_addr_t   chr_aout,
	output logic                     vram_a10,
	output logic                     vram_ce,
	output logic                     irq
);

	fds_disk_pkg::disk_status_t status;
	logic                       vertical;

	fds_timer_irq u_timer (
		.clk20  (clk20),
		.reset  (reset),
		.cpu_ce (cpu_ce),
		.cpu    (cpu),
		.irq    (irq)
	);

	fds_drive #(
		.DISK_SIDE_BYTES   (DISK_SIDE_BYTES),
		.DISK_HEADER_BYTES (DISK_HEADER_BYTES)
	) u_drive (
		.clk20       (clk20),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.cpu         (cpu),
		.side_manual (side_manual),
		.status      (status),
		.vertical    (vertical)
	);

	fds_bus_map u_map (
		.cpu       (cpu),
		.chr_ain   (chr_ain),
		.status    (status),
		.vertical  (vertical),
		.irq       (irq),
		.fds_swap  (fds_swap),
		.prg_rdata (prg_rdata),
		.prg_dout  (prg_dout),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce)
	);

endmodule

// File: rtl/fds_timer_irq.sv
// disk system timer interrupt with reload latch, repeat mode and acknowledge on status read
`timescale 1ns/10ps

module fds_timer_irq (
	input  logic                  clk20,
	input  logic                  reset,
	input  logic                  cpu_ce,
	input  fds_bus_pkg::cpu_bus_t cpu,
	output logic                  irq
);

	logic [15:0] timer_latch;
	logic [15:0] timer_cnt;
	logic        timer_repeat;
	logic        timer_en;
	logic        disk_reg_en;

	always_ff @(posedge clk20) begin
		if (reset) begin
			irq          <= 1'b0;
			timer_en     <= 1'b0;
			timer_repeat <= 1'b0;
			disk_reg_en  <= 1'b0;
		end else if (cpu_ce) begin
			// countdown, reload on expiry
			if (timer_en) begin
				if (timer_cnt == 16'd0) begin
					irq       <= 1'b1;
					timer_cnt <= timer_latch;
					if (!timer_repeat)
						timer_en <= 1'b0;
				end else begin
					timer_cnt <= timer_cnt - 16'd1;
				end
			end

			if (cpu.write) begin
				case (cpu.addr)
					fds_bus_pkg::TIMER_LO: timer_latch[7:0]  <= cpu.wdata;
					fds_bus_pkg::TIMER_HI: timer_latch[15:8] <= cpu.wdata;
					fds_bus_pkg::TIMER_CTRL: begin
						timer_repeat <= cpu.wdata[0];
						timer_en     <= cpu.wdata[1] & disk_reg_en;
						if (cpu.wdata[1] && disk_reg_en)
							timer_cnt <= timer_latch;
						else
							irq <= 1'b0;
					end
					fds_bus_pkg::DISK_ENABLE: begin
						disk_reg_en <= cpu.wdata[0];
						// disabling the disk registers stops the timer too
						if (!cpu.wdata[0]) begin
							timer_en <= 1'b0;
							irq      <= 1'b0;
						end
					end
					default: ;
				endcase
			end

			// status read acknowledges, wins over a same-strobe expiry
			if (!cpu.write && cpu.addr == fds_bus_pkg::IRQ_STATUS)
				irq <= 1'b0;
		end
	end

	a_irq_needs_disk_en: assert property (
		@(posedge clk20) disable iff (reset)
		$rose(irq) |-> disk_reg_en
	);

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_fds_mapper \
	-f src.f -o sim_fds_mapper &&
./obj_dir/sim_fds_mapper | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run passed" || { echo "run failed"; exit 1; }

// File: src.f
rtl/fds_bus_pkg.sv
rtl/fds_disk_pkg.sv
rtl/fds_timer_irq.sv
rtl/fds_drive.sv
rtl/fds_bus_map.sv
rtl/fds_mapper.sv
verification/tb_fds_mapper.sv

// File: verification/tb_fds_mapper.sv
// testbench for the disk system mapper, random bus traffic checked against a behavioral model
`timescale 1ns/10ps

module tb_fds_mapper;

	localparam int SIDE_BYTES   = 3000;
	localparam int HDR_BYTES    = 16;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE   = 0;
	localparam int ARMED  = 1;
	localparam int ACTIVE = 2;

	// test lengths in bus accesses, about three clocks each
	localparam int TIMER_LEN   = 80;
	localparam int READ_LEN    = 3 * SIDE_BYTES + 12;
	localparam int SIDE_LEN    = 125;
	localparam int WRITE_LEN   = 12;
	localparam int MAP_LEN     = 305;
	localparam int CYCLE_LIMIT =
		2 * (RESET_CYCLES + 3 * (TIMER_LEN + READ_LEN + SIDE_LEN + WRITE_LEN + MAP_LEN));

	logic                       clk20;
	logic                       reset;
	logic                       cpu_ce;
	fds_bus_pkg::cpu_bus_t      cpu;
	fds_bus_pkg::ppu_addr_t     chr_ain;
	fds_disk_pkg::disk_side_t   side_manual;
	logic                       fds_swap;
	fds_bus_pkg::cpu_data_t     prg_rdata;
	fds_bus_pkg::cpu_data_t     prg_dout;
	fds_bus_pkg::prg_addr_t     prg_aout;
	logic                       prg_allow;
	fds_bus_pkg::chr_addr_t     chr_aout;
	logic                       vram_a10;
	logic                       vram_ce;
	logic                       irq;

	// model state
	logic        m_irq;
	logic        m_ten;
	logic        m_rep;
	logic        m_dren;
	logic [15:0] m_latch;
	logic [15:0] m_cnt;
	logic        m_disk_reset;
	logic        m_we;
	logic        m_vertical;
	logic [1:0]  m_side_auto;
	logic        m_saved;
	int          m_rd;
	int          m_wr;
	int          m_pos;

	int errors;
	int checks;
	int cycles;

	fds_mapper #(
		.DISK_SIDE_BYTES   (SIDE_BYTES),
		.DISK_HEADER_BYTES (HDR_BYTES)
	) uut (
		.clk20       (clk20),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.cpu         (cpu),
		.chr_ain     (chr_ain),
		.side_manual (side_manual),
		.fds_swap    (fds_swap),
		.prg_rdata   (prg_rdata),
		.prg_dout    (prg_dout),
		.prg_aout    (prg_aout),
		.prg_allow   (prg_allow),
		.chr_aout    (chr_aout),
		.vram_a10    (vram_a10),
		.vram_ce     (vram_ce),
		.irq         (irq)
	);

	always #20 clk20 = ~clk20;

	always @(posedge clk20) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic check_data(input string name, input fds_bus_pkg::cpu_data_t got,
		input fds_bus_pkg::cpu_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_prg(input string name, input fds_bus_pkg::prg_addr_t got,
		input fds_bus_pkg::prg_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_chr(input string name, input fds_bus_pkg::chr_addr_t got,
		input fds_bus_pkg::chr_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// header, then whole sides, then the position
	function automatic fds_disk_pkg::image_off_t exp_offset();
		int side;
		side = (int'(m_side_auto) + int'(side_manual)) % 4;
		return fds_disk_pkg::image_off_t'(HDR_BYTES + SIDE_BYTES * side + m_pos);
	endfunction

	function automatic logic xfer_on();
		return (m_rd == ACTIVE) || (m_wr == ACTIVE);
	endfunction

	function automatic logic bios_port(input fds_bus_pkg::cpu_addr_t a);
		return a == fds_bus_pkg::READ_LO || a == fds_bus_pkg::READ_HI ||
			a == fds_bus_pkg::WRITE_LO || a == fds_bus_pkg::WRITE_HI;
	endfunction

	function automatic fds_bus_pkg::cpu_data_t exp_dout(input fds_bus_pkg::cpu_addr_t a,
		input fds_bus_pkg::cpu_data_t rdata);
		fds_disk_pkg::image_off_t off;
		logic at_end;
		off = exp_offset();
		at_end = (m_pos == SIDE_BYTES - 1);
		if (a == fds_bus_pkg::IRQ_STATUS)
			return {7'd0, m_irq};
		if (a == fds_bus_pkg::DRIVE_STATUS)
			return {5'd0, fds_swap, at_end, fds_swap};
		if (a == fds_bus_pkg::POWER_STATUS)
			return 8'h80;
		if ((a == fds_bus_pkg::READ_LO || a == fds_bus_pkg::WRITE_LO) && !xfer_on())
			return off[7:0];
		if ((a == fds_bus_pkg::READ_HI || a == fds_bus_pkg::WRITE_HI) && !xfer_on())
			return {3'b111, off[12:8]};
		if (a == fds_bus_pkg::SAVE_FLAG)
			return {7'd0, m_saved};
		return rdata;
	endfunction

	function automatic fds_bus_pkg::prg_addr_t exp_prg(input fds_bus_pkg::cpu_addr_t a);
		fds_disk_pkg::image_off_t off;
		logic [5:0] bank;
		off = exp_offset();
		if (a >= 16'hE000)
			bank = xfer_on() ? {1'b1, off[17:13]} : 6'd0;
		else
			bank = {4'b0001, a[14:13]};
		return {3'b000, bank, a[12:0]};
	endfunction

	function automatic logic exp_allow(input fds_bus_pkg::cpu_bus_t b);
		if (b.write)
			return (b.addr >= 16'h6000 && b.addr <= 16'hDFFF) || m_wr == ACTIVE;
		return b.addr >= 16'h6000 && !(bios_port(b.addr) && !xfer_on());
	endfunction

	function automatic fds_bus_pkg::chr_addr_t exp_chr(input fds_bus_pkg::ppu_addr_t c);
		logic a10;
		a10 = (c[13] && !m_vertical) ? c[11] : c[10];
		return {3'b100, 6'd0, c[12:11], a10, c[9:0]};
	endfunction

	task automatic check_outputs();
		fds_bus_pkg::chr_addr_t c;
		c = exp_chr(chr_ain);
		check_data("prg_dout", prg_dout, exp_dout(cpu.addr, prg_rdata));
		check_prg("prg_aout", prg_aout, exp_prg(cpu.addr));
		check_bit("prg_allow", prg_allow, exp_allow(cpu));
		check_chr("chr_aout", chr_aout, c);
		check_bit("vram_a10", vram_a10, c[10]);
		check_bit("vram_ce", vram_ce, chr_ain[13]);
		check_bit("irq", irq, m_irq);
	endtask

	// state change on one counted access, from the values before the edge
	task automatic model_step(input fds_bus_pkg::cpu_bus_t b);
		logic rd;
		int   rd_next;
		int   wr_next;
		rd = !b.write;
		if (m_disk_reset)
			m_pos = 0;
		else if (m_rd == ACTIVE && m_pos != SIDE_BYTES - 1)
			m_pos++;
		if (m_wr == ACTIVE)
			m_saved = 1'b1;
		rd_next = IDLE;
		if (rd && b.addr == fds_bus_pkg::READ_LO)
			rd_next = ARMED;
		else if (rd && b.addr == fds_bus_pkg::READ_HI && m_rd == ARMED)
			rd_next = ACTIVE;
		wr_next = IDLE;
		if (rd && m_we && b.addr == fds_bus_pkg::WRITE_LO)
			wr_next = ARMED;
		else if (rd && b.addr == fds_bus_pkg::WRITE_HI && m_wr == ARMED)
			wr_next = ACTIVE;
		m_rd = rd_next;
		m_wr = wr_next;
		if (m_ten) begin
			if (m_cnt == 16'd0) begin
				m_irq = 1'b1;
				m_cnt = m_latch;
				if (!m_rep)
					m_ten = 1'b0;
			end else begin
				m_cnt = m_cnt - 16'd1;
			end
		end
		if (b.write) begin
			case (b.addr)
				fds_bus_pkg::TIMER_LO: m_latch[7:0] = b.wdata;
				fds_bus_pkg::TIMER_HI: m_latch[15:8] = b.wdata;
				fds_bus_pkg::TIMER_CTRL: begin
					m_rep = b.wdata[0];
					m_ten = b.wdata[1] && m_dren;
					if (m_ten)
						m_cnt = m_latch;
					else
						m_irq = 1'b0;
				end
				fds_bus_pkg::DISK_ENABLE: begin
					m_dren = b.wdata[0];
					if (!m_dren) begin
						m_ten = 1'b0;
						m_irq = 1'b0;
					end
				end
				fds_bus_pkg::DRIVE_CTRL: begin
					m_disk_reset = b.wdata[1];
					m_we         = !b.wdata[2];
					m_vertical   = !b.wdata[3];
				end
				fds_bus_pkg::SIDE_SEL: m_side_auto = b.wdata[1:0];
				default: ;
			endcase
		end else if (b.addr == fds_bus_pkg::IRQ_STATUS) begin
			m_irq = 1'b0;
		end
	endtask

	// holds the bus until a strobe lands, checking every cycle on the way
	task automatic access(input fds_bus_pkg::cpu_addr_t addr, input fds_bus_pkg::cpu_data_t wdata,
		input logic write, output fds_bus_pkg::cpu_data_t rdata, output logic allow);
		logic        ce;
		logic [31:0] r;
		ce = 1'b0;
		cpu.addr  = addr;
		cpu.wdata = wdata;
		cpu.write = write;
		while (!ce) begin
			r = $urandom;
			ce        = (r % 3) == 0;
			cpu_ce    = ce;
			r         = $urandom;
			prg_rdata = r[7:0];
			chr_ain   = r[21:8];
			fds_swap  = r[31];
			#10;
			check_outputs();
			rdata = prg_dout;
			allow = prg_allow;
			@(posedge clk20);
			#2;
		end
		model_step(cpu);
		cpu_ce = 1'b0;
	endtask

	task automatic bus_write(input fds_bus_pkg::cpu_addr_t addr, input fds_bus_pkg::cpu_data_t data);
		fds_bus_pkg::cpu_data_t d;
		logic                   a;
		access(addr, data, 1'b1, d, a);
	endtask

	task automatic bus_read(input fds_bus_pkg::cpu_addr_t addr, output fds_bus_pkg::cpu_data_t d);
		logic a;
		access(addr, 8'h00, 1'b0, d, a);
	endtask

	task automatic report_test(input string name, input int start);
		if (errors == start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - start);
	endtask

	task automatic test_timer();
		fds_bus_pkg::cpu_data_t d;
		logic [31:0]            r;
		int                     start;
		start = errors;
		r = $urandom;
		bus_write(fds_bus_pkg::DISK_ENABLE, 8'h01);
		bus_write(fds_bus_pkg::TIMER_LO, {4'd0, r[3:0]});
		bus_write(fds_bus_pkg::TIMER_HI, 8'h00);
		for (int rep = 1; rep >= 0; rep--) begin
			bus_write(fds_bus_pkg::TIMER_CTRL, {6'd0, 1'b1, rep[0]});
			repeat (r[3:0]) bus_read(16'h0000, d);
			check_bit("irq", irq, 1'b0);
			bus_read(16'h0000, d);
			check_bit("irq", irq, 1'b1);
			bus_read(fds_bus_pkg::IRQ_STATUS, d);
			check_data("prg_dout", d, 8'h01);
			check_bit("irq", irq, 1'b0);
			// only repeat mode fires a second time
			repeat (r[3:0] + 1) bus_read(16'h0000, d);
			check_bit("irq", irq, rep[0]);
			bus_write(fds_bus_pkg::TIMER_CTRL, 8'h00);
		end
		report_test("timer", start);
	endtask

	task automatic test_read_xfer();
		fds_bus_pkg::cpu_data_t d;
		logic [31:0]            r;
		int                     start;
		start = errors;
		// disk reset, then side 3 so the offset lies above the first bank
		bus_write(fds_bus_pkg::DRIVE_CTRL, 8'h06);
		bus_read(16'h0000, d);
		bus_write(fds_bus_pkg::DRIVE_CTRL, 8'h04);
		bus_write(fds_bus_pkg::SIDE_SEL, 8'h03);
		repeat (SIDE_BYTES + 2) begin
			r = $urandom;
			bus_read(fds_bus_pkg::READ_LO, d);
			bus_read(fds_bus_pkg::READ_HI, d);
			bus_read({3'b111, r[12:0]}, d);
		end
		bus_read(fds_bus_pkg::DRIVE_STATUS, d);
		check_bit("disk_end", d[1], 1'b1);
		report_test("read transfer", start);
	endtask

	task automatic test_side_select();
		fds_bus_pkg::cpu_data_t   d;
		fds_disk_pkg::image_off_t off;
		logic [31:0]              r;
		int                       start;
		start = errors;
		bus_write(fds_bus_pkg::DRIVE_CTRL, 8'h06);
		bus_write(fds_bus_pkg::DRIVE_CTRL, 8'h04);
		repeat (40) begin
			r = $urandom;
			side_manual = r[1:0];
			bus_write(fds_bus_pkg::SIDE_SEL, {6'd0, r[3:2]});
			off = exp_offset();
			bus_read(fds_bus_pkg::READ_LO, d);
			check_data("prg_dout", d, off[7:0]);
			bus_read(fds_bus_pkg::READ_HI, d);
			check_data("prg_dout", d, {3'b111, off[12:8]});
		end
		report_test("side select", start);
	endtask

	task automatic test_write_xfer();
		fds_bus_pkg::cpu_data_t d;
		logic                   allow;
		logic [31:0]            r;
		int                     start;
		start = errors;
		r = $urandom;
		bus_write(fds_bus_pkg::DRIVE_CTRL, 8'h00);
		// nothing written yet
		bus_read(fds_bus_pkg::SAVE_FLAG, d);
		check_data("prg_dout", d, 8'h00);
		bus_read(fds_bus_pkg::WRITE_LO, d);
		bus_read(fds_bus_pkg::WRITE_HI, d);
		access(16'hE000, r[7:0], 1'b1, d, allow);
		check_bit("prg_allow", allow, 1'b1);
		bus_read(fds_bus_pkg::SAVE_FLAG, d);
		check_data("prg_dout", d, 8'h01);
		// write protected, so the handshake must not open
		bus_write(fds_bus_pkg::DRIVE_CTRL, 8'h04);
		bus_read(fds_bus_pkg::WRITE_LO, d);
		bus_read(fds_bus_pkg::WRITE_HI, d);
		access(16'h2000, r[15:8], 1'b1, d, allow);
		check_bit("prg_allow", allow, 1'b0);
		report_test("write transfer", start);
	endtask

	task automatic test_mapping();
		fds_bus_pkg::cpu_data_t d;
		logic                   allow;
		logic [31:0]            r;
		int                     start;
		start = errors;
		for (int mode = 0; mode < 2; mode++) begin
			bus_write(fds_bus_pkg::DRIVE_CTRL, mode[0] ? 8'h0C : 8'h04);
			repeat (150) begin
				r = $urandom;
				access(r[15:0], r[23:16], r[24], d, allow);
			end
		end
		report_test("mapping", start);
	endtask

	initial begin
		void'($urandom(24));
		clk20        = 1'b0;
		reset        = 1'b1;
		cpu_ce       = 1'b0;
		cpu          = '0;
		chr_ain      = '0;
		side_manual  = '0;
		fds_swap     = 1'b0;
		prg_rdata    = '0;
		errors       = 0;
		checks       = 0;
		cycles       = 0;
		m_irq        = 1'b0;
		m_ten        = 1'b0;
		m_rep        = 1'b0;
		m_dren       = 1'b0;
		m_latch      = '0;
		m_cnt        = '0;
		m_disk_reset = 1'b0;
		m_we         = 1'b0;
		m_vertical   = 1'b0;
		m_side_auto  = '0;
		m_saved      = 1'b0;
		m_rd         = IDLE;
		m_wr         = IDLE;
		m_pos        = 0;
		repeat (RESET_CYCLES) @(posedge clk20);
		#2;
		reset = 1'b0;
		test_timer();
		test_read_xfer();
		test_side_select();
		test_write_xfer();
		test_mapping();
		$display("5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
